// ==== include/his_config.svh ====
`ifndef HIS_CONFIG_SVH
`define HIS_CONFIG_SVH

// pixels delivered per acquisition, one hit record each
`define HIS_PIXEL_NUM 4

// time bins per pixel
`define HIS_BIN_NUM 16

// acquisitions summed into one histogram
`define HIS_ACQ_NUM 8

// count width
// must hold HIS_ACQ_NUM, counts never saturate
`define HIS_COUNT_W 8

`endif

// ==== hdl/his_types_pkg.sv ====
`include "his_config.svh"

package his_types_pkg;

    // index widths, kept at least one bit wide
    localparam int PIXEL_W = (`HIS_PIXEL_NUM > 1) ? $clog2(`HIS_PIXEL_NUM) : 1;
    localparam int BIN_W = (`HIS_BIN_NUM > 1) ? $clog2(`HIS_BIN_NUM) : 1;

    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [BIN_W-1:0] bin_t;
    typedef logic [`HIS_COUNT_W-1:0] count_t;

    // one hit record as delivered per pixel
    typedef struct packed {
        logic detected;
        bin_t bin;
    } hit_t;

    // one histogram word on the readout port
    // bank names the histogram that was just finished
    typedef struct packed {
        logic bank;
        pixel_t pixel;
        bin_t bin;
        count_t count;
    } his_word_t;

endpackage

// ==== hdl/his_ctrl_pkg.sv ====
package his_ctrl_pkg;

    // accumulation side of the controller
    // WAIT_DRAIN holds off the last hit while a drain is still running
    // DRAIN_LAST lets the final increment land before the drain starts
    typedef enum logic [1:0] {
        ACCUM,
        WAIT_DRAIN,
        DRAIN_LAST
    } ctrl_state_t;

    // count memory address, same layout on both ports
    typedef struct packed {
        logic bank;
        his_types_pkg::pixel_t pixel;
        his_types_pkg::bin_t bin;
    } ram_cmd_t;

endpackage

// ==== hdl/hit_rx.sv ====
`timescale 1ns/1ns

module hit_rx (
    input  logic                clk,
    input  logic                res,
    input  logic                hit_req,
    input  his_types_pkg::hit_t hit_data,
    output logic                hit_ack,
    output logic                hit_valid,
    output his_types_pkg::hit_t hit,
    input  logic                hit_ready
);

    logic idle;

    // neither offering a record nor acknowledging one
    assign idle = !hit_valid && !hit_ack;

    // phase FSM, state is carried by hit_valid and hit_ack
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit_valid <= 1'b0;
            hit_ack <= 1'b0;
        end else begin
            if (idle) begin
                // request seen, offer the record next cycle
                if (hit_req) begin
                    hit_valid <= 1'b1;
                end
            end else if (hit_valid) begin
                // controller took it, now acknowledge the source
                if (hit_ready) begin
                    hit_valid <= 1'b0;
                    hit_ack <= 1'b1;
                end
            end else if (!hit_req) begin
                // return to zero
                hit_ack <= 1'b0;
            end
        end
    end

    // record latched once, on the rising request
    always_ff @(posedge clk) begin
        if (idle && hit_req) begin
            hit <= hit_data;
        end
    end

    // source keeps its data until the acknowledge arrives
    a_hit_data_stable: assert property (
        @(posedge clk) disable iff (!res)
        (hit_req && !hit_ack) |=> (!hit_req || $stable(hit_data))
    );

endmodule

// ==== hdl/bin_ram.sv ====
`timescale 1ns/1ns

module bin_ram (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   inc_en,
    input  his_ctrl_pkg::ram_cmd_t inc_cmd,
    input  logic                   drain_en,
    input  his_ctrl_pkg::ram_cmd_t drain_cmd,
    output his_types_pkg::count_t  drain_count
);
    import his_types_pkg::*;
    import his_ctrl_pkg::*;

    // both banks, addressed by {bank, pixel, bin}
    localparam int DEPTH = 1 << $bits(ram_cmd_t);

    count_t mem [DEPTH];

    // stage one holds the address and the count read for it
    logic s1_en;
    ram_cmd_t s1_cmd;
    count_t s1_count;
    count_t s1_next;
    logic fwd;
    count_t rd_count;

    // banks start empty, the drain clears every word it reads
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign s1_next = s1_count + 1'b1;

    // same address as the write in flight
    // take its result, memory still holds the old count
    assign fwd = s1_en && (s1_cmd == inc_cmd);
    assign rd_count = fwd ? s1_next : mem[inc_cmd];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_en <= 1'b0;
        end else begin
            s1_en <= inc_en;
        end
    end

    always_ff @(posedge clk) begin
        if (inc_en) begin
            s1_cmd <= inc_cmd;
            s1_count <= rd_count;
        end
    end

    // stage two writes back, drain port reads and clears
    // the two never share a bank
    always @(posedge clk) begin
        if (s1_en) begin
            mem[s1_cmd] <= s1_next;
        end
        if (drain_en) begin
            drain_count <= mem[drain_cmd];
            mem[drain_cmd] <= '0;
        end
    end

    // drain only touches the finished bank, incl. the write in flight
    a_bank_split: assert property (
        @(posedge clk) disable iff (!res)
        drain_en |-> !(inc_en && inc_cmd.bank == drain_cmd.bank)
                  && !(s1_en && s1_cmd.bank == drain_cmd.bank)
    );

    // count width is sized for the acquisition count
    a_no_wrap: assert property (
        @(posedge clk) disable iff (!res)
        s1_en |-> (s1_count != '1)
    );

endmodule

// ==== hdl/readout_tx.sv ====
`timescale 1ns/1ns

module readout_tx (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     word_valid,
    input  his_types_pkg::his_word_t word,
    output logic                     word_ready,
    output logic                     out_req,
    output his_types_pkg::his_word_t out_word,
    input  logic                     out_ack
);

    // holding register occupied until the handshake is back at zero
    logic busy;
    logic take;

    assign word_ready = !busy;
    assign take = word_valid && word_ready;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            busy <= 1'b0;
            out_req <= 1'b0;
        end else begin
            if (take) begin
                // new word, request next cycle
                busy <= 1'b1;
                out_req <= 1'b1;
            end else if (out_req && out_ack) begin
                // consumer has it
                out_req <= 1'b0;
            end else if (busy && !out_req && !out_ack) begin
                // ack released, slot free again
                busy <= 1'b0;
            end
        end
    end

    // one-entry holding register
    always_ff @(posedge clk) begin
        if (take) begin
            out_word <= word;
        end
    end

    // consumer may sample out_word any time during the request
    a_out_word_stable: assert property (
        @(posedge clk) disable iff (!res)
        out_req |=> $stable(out_word)
    );

endmodule

// ==== hdl/his_builder_ctrl.sv ====
`timescale 1ns/1ns
`include "his_config.svh"

module his_builder_ctrl (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     hit_valid,
    input  his_types_pkg::hit_t      hit,
    output logic                     hit_ready,
    output logic                     inc_en,
    output his_ctrl_pkg::ram_cmd_t   inc_cmd,
    output logic                     drain_en,
    output his_ctrl_pkg::ram_cmd_t   drain_cmd,
    input  his_types_pkg::count_t    drain_count,
    output logic                     word_valid,
    output his_types_pkg::his_word_t word,
    input  logic                     word_ready,
    output logic                     his_num
);
    import his_types_pkg::*;
    import his_ctrl_pkg::*;

    localparam int ACQ_W = (`HIS_ACQ_NUM > 1) ? $clog2(`HIS_ACQ_NUM) : 1;
    localparam pixel_t PIX_LAST = pixel_t'(`HIS_PIXEL_NUM - 1);
    localparam bin_t BIN_LAST = bin_t'(`HIS_BIN_NUM - 1);
    localparam logic [ACQ_W-1:0] ACQ_LAST = ACQ_W'(`HIS_ACQ_NUM - 1);

    ctrl_state_t state;
    pixel_t pix;
    pixel_t pix_nxt;
    logic [ACQ_W-1:0] acq;
    logic [ACQ_W-1:0] acq_nxt;
    logic hit_take;
    logic is_last;
    logic next_last;
    logic settle;
    logic drain_start;
    logic drain_busy;
    logic drain_active;
    logic drain_done;
    logic rd_pend;
    ram_cmd_t d_cmd;
    ram_cmd_t rd_cmd;

    // accumulation side
    assign hit_ready = (state == ACCUM);
    assign hit_take = hit_valid && hit_ready;

    // pixel runs fastest, acquisition steps on pixel wrap
    always_comb begin
        pix_nxt = pixel_t'(pix + 1'b1);
        acq_nxt = acq;
        if (pix == PIX_LAST) begin
            pix_nxt = '0;
            acq_nxt = acq + 1'b1;
        end
    end

    assign is_last = (pix == PIX_LAST) && (acq == ACQ_LAST);
    assign next_last = (pix_nxt == PIX_LAST) && (acq_nxt == ACQ_LAST);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= ACCUM;
            pix <= '0;
            acq <= '0;
            settle <= 1'b0;
            his_num <= 1'b0;
            inc_en <= 1'b0;
        end else begin
            // undetected hits advance counters only
            inc_en <= hit_take && hit.detected;
            case (state)
                ACCUM: begin
                    if (hit_take) begin
                        if (is_last) begin
                            // histogram complete, swap banks
                            pix <= '0;
                            acq <= '0;
                            his_num <= ~his_num;
                            settle <= 1'b0;
                            state <= DRAIN_LAST;
                        end else begin
                            pix <= pix_nxt;
                            acq <= acq_nxt;
                            // last hit would overlap the running drain
                            if (next_last && drain_active) begin
                                state <= WAIT_DRAIN;
                            end
                        end
                    end
                end
                WAIT_DRAIN: begin
                    if (!drain_active) begin
                        state <= ACCUM;
                    end
                end
                DRAIN_LAST: begin
                    // two cycles for the last increment to be written
                    settle <= 1'b1;
                    if (settle) begin
                        state <= ACCUM;
                    end
                end
                default: begin
                    state <= ACCUM;
                end
            endcase
        end
    end

    // increment address uses the bank before any toggle
    always_ff @(posedge clk) begin
        if (hit_take) begin
            inc_cmd <= '{bank: his_num, pixel: pix, bin: hit.bin};
        end
    end

    // drain walker
    assign drain_start = (state == DRAIN_LAST) && settle;
    assign drain_active = drain_busy || rd_pend;

    // one read in flight, next one after the word is taken
    assign drain_en = drain_busy && !rd_pend;
    assign drain_cmd = d_cmd;
    assign drain_done = drain_en && (d_cmd.pixel == PIX_LAST) && (d_cmd.bin == BIN_LAST);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            drain_busy <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            if (drain_start) begin
                drain_busy <= 1'b1;
            end else if (drain_done) begin
                drain_busy <= 1'b0;
            end
            if (drain_en) begin
                rd_pend <= 1'b1;
            end else if (word_valid && word_ready) begin
                rd_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (drain_start) begin
            // his_num already names the new bank
            d_cmd <= '{bank: ~his_num, pixel: '0, bin: '0};
        end else if (drain_en) begin
            if (d_cmd.bin == BIN_LAST) begin
                d_cmd.bin <= '0;
                d_cmd.pixel <= pixel_t'(d_cmd.pixel + 1'b1);
            end else begin
                d_cmd.bin <= bin_t'(d_cmd.bin + 1'b1);
            end
        end
        if (drain_en) begin
            rd_cmd <= d_cmd;
        end
    end

    // drain_count holds until the next drain_en
    assign word_valid = rd_pend;
    assign word = '{bank: rd_cmd.bank, pixel: rd_cmd.pixel, bin: rd_cmd.bin,
                    count: drain_count};

endmodule

// ==== hdl/his_builder_top.sv ====
`timescale 1ns/1ns

module his_builder_top (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     hit_req,
    input  his_types_pkg::hit_t      hit_data,
    output logic                     hit_ack,
    output logic                     out_req,
    output his_types_pkg::his_word_t out_word,
    input  logic                     out_ack,
    output logic                     his_num
);
    import his_types_pkg::*;
    import his_ctrl_pkg::*;

    // receiver to controller
    logic hit_valid;
    logic hit_ready;
    hit_t hit;

    // controller to memory
    logic inc_en;
    ram_cmd_t inc_cmd;
    logic drain_en;
    ram_cmd_t drain_cmd;
    count_t drain_count;

    // controller to sender
    logic word_valid;
    logic word_ready;
    his_word_t word;

    hit_rx u_hit_rx (
        .clk       (clk),
        .res       (res),
        .hit_req   (hit_req),
        .hit_data  (hit_data),
        .hit_ack   (hit_ack),
        .hit_valid (hit_valid),
        .hit       (hit),
        .hit_ready (hit_ready)
    );

    his_builder_ctrl u_ctrl (
        .clk         (clk),
        .res         (res),
        .hit_valid   (hit_valid),
        .hit         (hit),
        .hit_ready   (hit_ready),
        .inc_en      (inc_en),
        .inc_cmd     (inc_cmd),
        .drain_en    (drain_en),
        .drain_cmd   (drain_cmd),
        .drain_count (drain_count),
        .word_valid  (word_valid),
        .word        (word),
        .word_ready  (word_ready),
        .his_num     (his_num)
    );

    bin_ram u_bin_ram (
        .clk         (clk),
        .res         (res),
        .inc_en      (inc_en),
        .inc_cmd     (inc_cmd),
        .drain_en    (drain_en),
        .drain_cmd   (drain_cmd),
        .drain_count (drain_count)
    );

    readout_tx u_readout_tx (
        .clk        (clk),
        .res        (res),
        .word_valid (word_valid),
        .word       (word),
        .word_ready (word_ready),
        .out_req    (out_req),
        .out_word   (out_word),
        .out_ack    (out_ack)
    );

endmodule

// ==== testbench/tb_his_builder.sv ====
`timescale 1ns/1ns
`include "his_config.svh"

module tb_his_builder;
    import his_types_pkg::*;

    localparam int NWORD = `HIS_PIXEL_NUM * `HIS_BIN_NUM;
    localparam int HITS = `HIS_PIXEL_NUM * `HIS_ACQ_NUM;
    // random hits, then all undetected, then single bin, then random behind a slow drain
    localparam int N_HIST = 4;
    localparam int SLOW_HIST = 2;
    localparam int SLOW_ACK = 40;
    // about 6 cycles per hit plus ack delay and handshake per word
    localparam int TIMEOUT = N_HIST * (HITS * 10 + NWORD * (SLOW_ACK + 10)) + 1000;

    logic clk = 1'b0;
    logic res;
    logic hit_req;
    hit_t hit_data;
    logic hit_ack;
    logic out_req;
    his_word_t out_word;
    logic out_ack;
    logic his_num;

    int errors = 0;
    int words_checked = 0;
    int cycles = 0;
    int cur_hist = 0;
    int max_wait [N_HIST];
    hit_t sent_q [$];
    his_word_t got_q [$];
    logic num_q [$];
    count_t ref_cnt [NWORD];
    his_word_t cw;
    logic cn;
    int seen;
    int delay;

    always #4 clk = ~clk;

    his_builder_top DUT (
        .clk      (clk),
        .res      (res),
        .hit_req  (hit_req),
        .hit_data (hit_data),
        .hit_ack  (hit_ack),
        .out_req  (out_req),
        .out_word (out_word),
        .out_ack  (out_ack),
        .his_num  (his_num)
    );

    task automatic report_value(input string name, input int got, input int exp);
        errors++;
        $display("FAIL %s: got %h expected %h", name, got, exp);
    endtask

    // expected counts of histogram h from the hits that were sent
    // hit i of a histogram belongs to pixel i mod pixel count
    function automatic void build_reference(input int h);
        hit_t r;
        for (int i = 0; i < NWORD; i++) begin
            ref_cnt[i] = '0;
        end
        for (int i = 0; i < HITS; i++) begin
            r = sent_q[h * HITS + i];
            if (r.detected) begin
                ref_cnt[(i % `HIS_PIXEL_NUM) * `HIS_BIN_NUM + r.bin]++;
            end
        end
    endfunction

    // four-phase source that changes data only while req is low
    task automatic send_hit(input hit_t r);
        int wait_cycles;
        @(posedge clk);
        #1;
        hit_data = r;
        hit_req = 1'b1;
        wait_cycles = 0;
        do begin
            @(posedge clk);
            wait_cycles++;
        end while (!hit_ack);
        if (wait_cycles > max_wait[cur_hist]) begin
            max_wait[cur_hist] = wait_cycles;
        end
        #1;
        hit_req = 1'b0;
        do @(posedge clk); while (hit_ack);
    endtask

    task automatic send_histogram(input int h);
        hit_t r;
        bin_t fixed_bin;
        fixed_bin = bin_t'($urandom % `HIS_BIN_NUM);
        cur_hist = h;
        for (int i = 0; i < HITS; i++) begin
            case (h)
                1: begin
                    r.detected = 1'b0;
                    r.bin = bin_t'($urandom % `HIS_BIN_NUM);
                end
                // back to back into one bin per pixel
                2: begin
                    r.detected = 1'b1;
                    r.bin = fixed_bin;
                end
                default: begin
                    r.detected = ($urandom % 4) != 0;
                    r.bin = bin_t'($urandom % `HIS_BIN_NUM);
                end
            endcase
            sent_q.push_back(r);
            send_hit(r);
        end
    endtask

    // words arrive pixel major and bin minor for one histogram after the other
    task automatic check_word(input his_word_t w, input logic num);
        int h;
        int idx;
        pixel_t exp_pix;
        bin_t exp_bin;
        logic exp_bank;
        h = words_checked / NWORD;
        idx = words_checked % NWORD;
        if (idx == 0) begin
            build_reference(h);
        end
        exp_pix = pixel_t'(idx / `HIS_BIN_NUM);
        exp_bin = bin_t'(idx % `HIS_BIN_NUM);
        exp_bank = 1'(h % 2);
        assert (w.bank == exp_bank) else report_value("out_word.bank", w.bank, exp_bank);
        assert (w.pixel == exp_pix) else report_value("out_word.pixel", w.pixel, exp_pix);
        assert (w.bin == exp_bin) else report_value("out_word.bin", w.bin, exp_bin);
        assert (w.count == ref_cnt[idx])
            else report_value("out_word.count", w.count, ref_cnt[idx]);
        // other bank is accumulating during the readout
        assert (num == !exp_bank) else report_value("his_num", num, !exp_bank);
        words_checked++;
    endtask

    // consumer takes word and his_num on the first cycle of out_req
    initial begin
        out_ack = 1'b0;
        seen = 0;
        forever begin
            @(posedge clk);
            if (out_req) begin
                got_q.push_back(out_word);
                num_q.push_back(his_num);
                delay = (seen / NWORD == SLOW_HIST) ? SLOW_ACK : seen % 3;
                seen++;
                repeat (delay) @(posedge clk);
                #1;
                out_ack = 1'b1;
                do @(posedge clk); while (out_req);
                #1;
                out_ack = 1'b0;
            end
        end
    end

    // comparator
    always @(posedge clk) begin
        if (got_q.size() > 0) begin
            cw = got_q.pop_front();
            cn = num_q.pop_front();
            check_word(cw, cn);
        end
    end

    // watchdog
    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d words checked",
                 cycles, words_checked, N_HIST * NWORD);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        res = 1'b0;
        hit_req = 1'b0;
        hit_data = '0;
        for (int i = 0; i < N_HIST; i++) begin
            max_wait[i] = 0;
        end
        void'($urandom(47));
        repeat (5) @(posedge clk);
        #1;
        res = 1'b1;
        @(posedge clk);
        assert (!hit_ack && !out_req && !his_num) else begin
            errors++;
            $display("handshake outputs or his_num not low after reset");
        end

        for (int h = 0; h < N_HIST; h++) begin
            send_histogram(h);
        end
        wait (words_checked == N_HIST * NWORD);

        // no word beyond the last histogram
        repeat (20) @(posedge clk);
        assert (seen == N_HIST * NWORD) else begin
            errors++;
            $display("%0d words read out where %0d were expected", seen, N_HIST * NWORD);
        end

        // toggled once per histogram
        assert (his_num == 1'(N_HIST % 2)) else report_value("his_num", his_num, N_HIST % 2);
        // last hit of the next histogram held back by the slow drain
        assert (max_wait[SLOW_HIST + 1] > 4 * SLOW_ACK) else begin
            errors++;
            $display("hit_ack was not withheld during the slow drain, longest wait %0d cycles",
                     max_wait[SLOW_HIST + 1]);
        end

        $display("checked %0d words, %0d errors", words_checked, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
hdl/his_types_pkg.sv
hdl/his_ctrl_pkg.sv
hdl/hit_rx.sv
hdl/bin_ram.sv
hdl/readout_tx.sv
hdl/his_builder_ctrl.sv
hdl/his_builder_top.sv
testbench/tb_his_builder.sv

// ==== Bender.yml ====
package:
  name: his_builder

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/his_types_pkg.sv
      - hdl/his_ctrl_pkg.sv
      - hdl/hit_rx.sv
      - hdl/bin_ram.sv
      - hdl/readout_tx.sv
      - hdl/his_builder_ctrl.sv
      - hdl/his_builder_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_his_builder.sv
